//--- src/ssa_config.svh
`ifndef SSA_CONFIG_SVH
`define SSA_CONFIG_SVH

// router geometry
`define SSA_P            5
`define SSA_V            2
`define SSA_FW           32
`define SSA_PORTW        3

// port numbering of the 5-port mesh router
`define SSA_PORT_LOCAL   0
`define SSA_PORT_EAST    1
`define SSA_PORT_NORTH   2
`define SSA_PORT_WEST    3
`define SSA_PORT_SOUTH   4
`define SSA_NO_PORT      5   // marks a port without straight partner

// flit field positions
`define SSA_HDR_BIT      31
`define SSA_TAIL_BIT     30
`define SSA_VC_MSB       29  // one-hot vc field
`define SSA_VC_LSB       28
`define SSA_DST_MSB      2   // absolute destination port, header only
`define SSA_DST_LSB      0

`endif

//--- src/ssa_pkg.sv
`include "ssa_config.svh"

package ssa_pkg;

    typedef logic [`SSA_FW-1:0]    flit_t;
    typedef logic [`SSA_PORTW-1:0] port_num_t;
    typedef logic [`SSA_V-1:0]     vc_mask_t;
    typedef logic [`SSA_P-1:0]     port_mask_t;

    // state of one input vc, as kept by the router
    typedef struct packed {
        logic      ivc_req;          // vc already competes for the switch
        logic      ovc_is_assigned;
        vc_mask_t  assigned_ovc;
        port_num_t dest_port;        // destination of the buffered packet
    } ivc_info_t;

    // decoded flit of one input port
    typedef struct packed {
        logic     wr;
        logic     hdr;
        logic     tail;
        vc_mask_t vc;
        logic     hdr_to_ss;         // header bound for the straight port
    } flit_info_t;

    typedef struct packed {
        logic ovc_allocated;
        logic ovc_released;
        logic sw_grant;
        logic ovc_grant;
        logic ivc_reset;
        logic credit_dec;
        logic single_flit;
    } vc_result_t;

    typedef struct packed {
        vc_mask_t                  ovc_is_allocated;      // per output vc
        vc_mask_t                  ovc_is_released;
        vc_mask_t                  buff_space_decreased;
        vc_mask_t                  ivc_num_getting_sw_grant;   // per input vc
        vc_mask_t                  ivc_num_getting_ovc_grant;
        vc_mask_t                  ivc_reset;
        vc_mask_t                  ivc_single_flit_pck;
        vc_mask_t                  ovc_single_flit_pck;
        vc_mask_t [`SSA_V-1:0]     ivc_granted_ovc_num;
        logic                      ssa_flit_wr;
    } ssa_ctrl_t;

    // east-west and north-south are the straight pairs
    function automatic port_num_t straight_port(input port_num_t port);
        port_num_t ss;
        case (port)
            port_num_t'(`SSA_PORT_EAST):  ss = port_num_t'(`SSA_PORT_WEST);
            port_num_t'(`SSA_PORT_WEST):  ss = port_num_t'(`SSA_PORT_EAST);
            port_num_t'(`SSA_PORT_NORTH): ss = port_num_t'(`SSA_PORT_SOUTH);
            port_num_t'(`SSA_PORT_SOUTH): ss = port_num_t'(`SSA_PORT_NORTH);
            port_num_t'(`SSA_PORT_LOCAL): ss = port_num_t'(`SSA_NO_PORT);
            default:                      ss = port_num_t'(`SSA_NO_PORT);
        endcase
        return ss;
    endfunction

endpackage

//--- src/ssa_flit_decode.sv
`timescale 1ns/1ps
`include "ssa_config.svh"

module ssa_flit_decode #(
    parameter int MY_PORT = 0
) (
    input  logic                flit_wr_i,
    input  ssa_pkg::flit_t      flit_i,
    output ssa_pkg::flit_info_t info_o
);
    import ssa_pkg::*;

    localparam port_num_t SS_PORT  = straight_port(port_num_t'(MY_PORT));
    localparam bit        HAS_SS   = (SS_PORT != port_num_t'(`SSA_NO_PORT));

    vc_mask_t  vc_field;
    port_num_t dest_port;
    logic      hdr_flag;
    logic      tail_flag;

    assign vc_field  = flit_i[`SSA_VC_MSB:`SSA_VC_LSB];
    assign dest_port = flit_i[`SSA_DST_MSB:`SSA_DST_LSB];
    assign hdr_flag  = flit_i[`SSA_HDR_BIT];
    assign tail_flag = flit_i[`SSA_TAIL_BIT];

    // flags only count with a write
    always_comb begin
        info_o.wr        = flit_wr_i;
        info_o.hdr       = flit_wr_i & hdr_flag;
        info_o.tail      = flit_wr_i & tail_flag;
        info_o.vc        = flit_wr_i ? vc_field : '0;
        info_o.hdr_to_ss = 1'b0;
        if (HAS_SS) begin
            // destination is absolute, so a plain compare does it
            info_o.hdr_to_ss = flit_wr_i & hdr_flag & (dest_port == SS_PORT);
        end
    end

    // the upstream router marks exactly one vc per flit
    always_comb begin
        if (flit_wr_i) begin
            assert ($onehot(vc_field))
                else $error("port %0d: vc field %b not one-hot", MY_PORT, vc_field);
        end
    end

endmodule

//--- src/ssa_vc_decide.sv
`timescale 1ns/1ps

module ssa_vc_decide #(
    parameter int MY_PORT = 1,
    parameter int VC_IDX  = 0
) (
    input  ssa_pkg::flit_info_t info_i,
    input  ssa_pkg::ivc_info_t  ivc_info_i,
    input  logic                port_sw_granted_i,   // some vc of this input holds the switch
    input  logic                ss_ovc_granted_i,    // straight output taken by another input
    input  logic                ss_ovc_avail_i,
    input  logic                ss_ovc_full_i,
    output ssa_pkg::vc_result_t result_o
);
    import ssa_pkg::*;

    localparam port_num_t SS_PORT = straight_port(port_num_t'(MY_PORT));

    logic ss_wr;
    logic single;
    logic assigned_ready;
    logic ovc_ready;
    logic permitted;
    logic pass_flit;
    logic pass_hdr;
    logic reset_vc;

    always_comb begin
        // an existing assignment has to be this vc of the straight port
        assigned_ready = ivc_info_i.assigned_ovc[VC_IDX]
                       & ~ss_ovc_full_i
                       & (ivc_info_i.dest_port == SS_PORT);

        ovc_ready = ivc_info_i.ovc_is_assigned ? assigned_ready : ss_ovc_avail_i;

        permitted = ovc_ready
                  & ~ivc_info_i.ivc_req
                  & ~port_sw_granted_i
                  & ~ss_ovc_granted_i;

        ss_wr  = info_i.wr & info_i.vc[VC_IDX];     // flit lands on this vc
        single = info_i.hdr & info_i.tail;

        // body and tail always follow, a header only when bound straight
        pass_flit = ss_wr & permitted & (~info_i.hdr | info_i.hdr_to_ss);
        pass_hdr  = ss_wr & permitted & info_i.hdr & info_i.hdr_to_ss;

        if (single) begin
            reset_vc = pass_flit;
        end else begin
            reset_vc = info_i.tail & ss_wr & permitted;
        end

        result_o.sw_grant      = pass_flit;
        result_o.credit_dec    = pass_flit;
        result_o.ovc_grant     = pass_hdr;
        result_o.ivc_reset     = reset_vc;
        result_o.ovc_released  = reset_vc & ~single;   // single flit never holds an ovc
        result_o.ovc_allocated = pass_hdr & ~single;
        result_o.single_flit   = single & pass_flit;   // flagged with the bypassed flit only
    end

endmodule

//--- src/ssa_port_ctrl.sv
`timescale 1ns/1ps
`include "ssa_config.svh"

module ssa_port_ctrl #(
    parameter int MY_PORT = 0
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ssa_pkg::vc_result_t own_vc_i [`SSA_V],   // this port as input
    input  ssa_pkg::vc_result_t in_vc_i  [`SSA_V],   // input that feeds this port
    output ssa_pkg::ssa_ctrl_t  ctrl_o
);
    import ssa_pkg::*;

    logic any_in_sw_grant;
    logic flit_wr_q;

    always_comb begin
        any_in_sw_grant = 1'b0;
        for (int v = 0; v < `SSA_V; v++) begin
            any_in_sw_grant |= in_vc_i[v].sw_grant;
        end
    end

    // bypassed flit reaches the output one cycle later
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flit_wr_q <= 1'b0;
        end else begin
            flit_wr_q <= any_in_sw_grant;
        end
    end

    always_comb begin
        ctrl_o = '0;
        for (int v = 0; v < `SSA_V; v++) begin
            // input side
            ctrl_o.ivc_num_getting_sw_grant[v]  = own_vc_i[v].sw_grant;
            ctrl_o.ivc_num_getting_ovc_grant[v] = own_vc_i[v].ovc_grant;
            ctrl_o.ivc_reset[v]                 = own_vc_i[v].ivc_reset;
            ctrl_o.ivc_single_flit_pck[v]       = own_vc_i[v].single_flit;
            ctrl_o.ivc_granted_ovc_num[v][v]    = own_vc_i[v].ovc_grant;  // straight keeps vc

            // output side
            ctrl_o.ovc_is_allocated[v]          = in_vc_i[v].ovc_allocated;
            ctrl_o.ovc_is_released[v]           = in_vc_i[v].ovc_released;
            ctrl_o.buff_space_decreased[v]      = in_vc_i[v].credit_dec;
            ctrl_o.ovc_single_flit_pck[v]       = in_vc_i[v].single_flit;
        end
        ctrl_o.ssa_flit_wr = flit_wr_q;
    end

    // header and tail of one packet never pass in the same cycle
    a_alloc_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ctrl_o.ovc_is_allocated & ctrl_o.ovc_is_released) == '0)
        else $error("port %0d: ovc allocated and released together", MY_PORT);

    // every write strobe pairs with a credit taken one cycle before
    a_wr_after_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctrl_o.ssa_flit_wr |-> $past(|ctrl_o.buff_space_decreased))
        else $error("port %0d: flit write without earlier credit decrease", MY_PORT);

endmodule

//--- src/ss_allocator.sv
`timescale 1ns/1ps
`include "ssa_config.svh"

module ss_allocator (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ssa_pkg::port_mask_t flit_in_wr_i,
    input  ssa_pkg::flit_t      flit_in_i          [`SSA_P],
    input  ssa_pkg::port_mask_t any_ovc_granted_i,                // per output port
    input  ssa_pkg::port_mask_t any_ivc_sw_grant_i,               // per input port
    input  ssa_pkg::vc_mask_t   ovc_avail_i        [`SSA_P],
    input  ssa_pkg::vc_mask_t   ovc_full_i         [`SSA_P],
    input  ssa_pkg::ivc_info_t  ivc_info_i         [`SSA_P][`SSA_V],
    output ssa_pkg::ssa_ctrl_t  ssa_ctrl_o         [`SSA_P]
);
    import ssa_pkg::*;

    flit_info_t flit_info [`SSA_P];
    vc_result_t vc_res    [`SSA_P][`SSA_V];   // results by input port
    vc_result_t feed_res  [`SSA_P][`SSA_V];   // results by output port

    genvar p;
    genvar v;

    generate
        for (p = 0; p < `SSA_P; p++) begin : g_in
            localparam port_num_t SS = straight_port(port_num_t'(p));

            ssa_flit_decode #(
                .MY_PORT (p)
            ) u_decode (
                .flit_wr_i (flit_in_wr_i[p]),
                .flit_i    (flit_in_i[p]),
                .info_o    (flit_info[p])
            );

            if (SS == port_num_t'(`SSA_NO_PORT)) begin : g_no_ss
                for (v = 0; v < `SSA_V; v++) begin : g_vc
                    assign vc_res[p][v] = '0;   // local port never bypasses
                end
            end else begin : g_ss
                for (v = 0; v < `SSA_V; v++) begin : g_vc
                    ssa_vc_decide #(
                        .MY_PORT (p),
                        .VC_IDX  (v)
                    ) u_vc_decide (
                        .info_i            (flit_info[p]),
                        .ivc_info_i        (ivc_info_i[p][v]),
                        .port_sw_granted_i (any_ivc_sw_grant_i[p]),
                        .ss_ovc_granted_i  (any_ovc_granted_i[SS]),
                        .ss_ovc_avail_i    (ovc_avail_i[SS][v]),
                        .ss_ovc_full_i     (ovc_full_i[SS][v]),
                        .result_o          (vc_res[p][v])
                    );
                end
            end
        end

        for (p = 0; p < `SSA_P; p++) begin : g_out
            // pairs are symmetric, so the feeder is the straight port itself
            localparam port_num_t FEED = straight_port(port_num_t'(p));

            for (v = 0; v < `SSA_V; v++) begin : g_vc
                if (FEED == port_num_t'(`SSA_NO_PORT)) begin : g_none
                    assign feed_res[p][v] = '0;
                end else begin : g_feed
                    assign feed_res[p][v] = vc_res[FEED][v];
                end
            end

            ssa_port_ctrl #(
                .MY_PORT (p)
            ) u_port_ctrl (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .own_vc_i (vc_res[p]),
                .in_vc_i  (feed_res[p]),
                .ctrl_o   (ssa_ctrl_o[p])
            );
        end
    endgenerate

endmodule

//--- testbench/tb_ss_allocator.sv
`timescale 1ns/1ps
`include "ssa_config.svh"

module tb_ss_allocator;
    import ssa_pkg::*;

    localparam int CLK_HALF    = 4;
    localparam int DRIVE_DLY   = 1;
    localparam int SAMPLE_DLY  = 7;     // just before the next rising edge
    localparam int RST_CYCLES  = 4;
    localparam int RST_TIMEOUT = 20;
    localparam int RAND_CYCLES = 2000;
    localparam int MAX_CYCLES  = 4000;
    localparam int LOCAL       = `SSA_PORT_LOCAL;
    localparam int EAST        = `SSA_PORT_EAST;
    localparam int NORTH       = `SSA_PORT_NORTH;
    localparam int WEST        = `SSA_PORT_WEST;

    logic       clk;
    logic       rst_n_i;
    port_mask_t flit_in_wr_i;
    flit_t      flit_in_i          [`SSA_P];
    port_mask_t any_ovc_granted_i;
    port_mask_t any_ivc_sw_grant_i;
    vc_mask_t   ovc_avail_i        [`SSA_P];
    vc_mask_t   ovc_full_i         [`SSA_P];
    ivc_info_t  ivc_info_i         [`SSA_P][`SSA_V];
    ssa_ctrl_t  ssa_ctrl_o         [`SSA_P];

    ssa_ctrl_t         exp_c [`SSA_P];        // hand-built expectations of directed cases
    logic [`SSA_P-1:0] exp_wr_q = '0;         // strobe expected in the current cycle
    logic [31:0]       lcg_state = 32'd85;
    logic              sim_done = 1'b0;
    int unsigned       ctrl_errs = 0;
    int unsigned       wr_errs = 0;

    ss_allocator dut_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .flit_in_wr_i       (flit_in_wr_i),
        .flit_in_i          (flit_in_i),
        .any_ovc_granted_i  (any_ovc_granted_i),
        .any_ivc_sw_grant_i (any_ivc_sw_grant_i),
        .ovc_avail_i        (ovc_avail_i),
        .ovc_full_i         (ovc_full_i),
        .ivc_info_i         (ivc_info_i),
        .ssa_ctrl_o         (ssa_ctrl_o)
    );

    always #CLK_HALF clk = ~clk;

    initial begin
        rst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY rst_n_i = 1'b1;
    end

    function automatic int partner_of(input int p);
        case (p)
            `SSA_PORT_EAST:  return `SSA_PORT_WEST;
            `SSA_PORT_WEST:  return `SSA_PORT_EAST;
            `SSA_PORT_NORTH: return `SSA_PORT_SOUTH;
            `SSA_PORT_SOUTH: return `SSA_PORT_NORTH;
            default:         return `SSA_NO_PORT;    // local goes nowhere straight
        endcase
    endfunction

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];    // upper bits, the low ones repeat quickly
    endfunction

    function automatic flit_t make_flit(input logic hdr, input logic tail, input int vc,
                                        input int dest);
        flit_t f;
        f = '0;
        f[`SSA_HDR_BIT]              = hdr;
        f[`SSA_TAIL_BIT]             = tail;
        f[`SSA_VC_LSB + vc]          = 1'b1;
        f[`SSA_DST_MSB:`SSA_DST_LSB] = port_num_t'(dest);
        return f;
    endfunction

    // expected pulses of input vc v on port p
    function automatic vc_result_t ref_vc(input int p, input int v);
        vc_result_t r;
        ivc_info_t  info;
        int         s;
        logic       wr;
        logic       hdr;
        logic       tail;
        logic       on_vc;
        logic       to_ss;
        logic       ready;
        logic       ok;
        logic       single;
        logic       go;
        r = '0;
        s = partner_of(p);
        if (s == `SSA_NO_PORT) begin
            return r;
        end
        wr    = flit_in_wr_i[p];
        hdr   = wr & flit_in_i[p][`SSA_HDR_BIT];
        tail  = wr & flit_in_i[p][`SSA_TAIL_BIT];
        on_vc = wr & flit_in_i[p][`SSA_VC_LSB + v];
        to_ss = hdr & (int'(flit_in_i[p][`SSA_DST_MSB:`SSA_DST_LSB]) == s);
        info  = ivc_info_i[p][v];
        if (info.ovc_is_assigned) begin
            ready = info.assigned_ovc[v] & ~ovc_full_i[s][v] & (int'(info.dest_port) == s);
        end else begin
            ready = ovc_avail_i[s][v];
        end
        ok     = ready & ~info.ivc_req & ~any_ivc_sw_grant_i[p] & ~any_ovc_granted_i[s];
        single = hdr & tail;
        go     = on_vc & ok & (~hdr | to_ss);
        r.sw_grant      = go;
        r.credit_dec    = go;
        r.ovc_grant     = on_vc & ok & hdr & to_ss;
        r.ivc_reset     = single ? go : (tail & on_vc & ok);
        r.ovc_released  = r.ivc_reset & ~single;
        r.ovc_allocated = r.ovc_grant & ~single;
        r.single_flit   = single & go;
        return r;
    endfunction

    function automatic ssa_ctrl_t ssa_ref(input int p);
        ssa_ctrl_t  c;
        vc_result_t own;
        vc_result_t feed;
        int         s;
        c = '0;
        s = partner_of(p);
        for (int v = 0; v < `SSA_V; v++) begin
            own  = ref_vc(p, v);
            feed = ref_vc(s, v);    // zero for the local port
            c.ivc_num_getting_sw_grant[v]  = own.sw_grant;
            c.ivc_num_getting_ovc_grant[v] = own.ovc_grant;
            c.ivc_reset[v]                 = own.ivc_reset;
            c.ivc_single_flit_pck[v]       = own.single_flit;
            c.ivc_granted_ovc_num[v][v]    = own.ovc_grant;
            c.ovc_is_allocated[v]          = feed.ovc_allocated;
            c.ovc_is_released[v]           = feed.ovc_released;
            c.buff_space_decreased[v]      = feed.credit_dec;
            c.ovc_single_flit_pck[v]       = feed.single_flit;
        end
        c.ssa_flit_wr = exp_wr_q[p];
        return c;
    endfunction

    function automatic logic feed_sw_grant(input int p);
        vc_result_t r;
        logic       hit;
        hit = 1'b0;
        for (int v = 0; v < `SSA_V; v++) begin
            r   = ref_vc(partner_of(p), v);
            hit = hit | r.sw_grant;
        end
        return hit;
    endfunction

    task automatic check_ctrl(input ssa_ctrl_t act, input ssa_ctrl_t want, input int p);
        ssa_ctrl_t a;
        ssa_ctrl_t e;
        a = act;
        e = want;
        a.ssa_flit_wr = 1'b0;
        e.ssa_flit_wr = 1'b0;
        if (a !== e) begin
            ctrl_errs++;
            $display("FAILED at %0t: ssa_ctrl_o[%0d] expected %h, got %h", $time, p, e, a);
        end
    endtask

    task automatic check_flit_wr(input logic act, input logic want, input int p);
        if (act !== want) begin
            wr_errs++;
            $display("FAILED at %0t: ssa_ctrl_o[%0d].ssa_flit_wr expected %b, got %b",
                     $time, p, want, act);
        end
    endtask

    // every cycle, all ports against the reference
    always @(posedge clk) begin
        logic [`SSA_P-1:0] wr_next;
        ssa_ctrl_t         want;
        #SAMPLE_DLY;
        for (int p = 0; p < `SSA_P; p++) begin
            want = ssa_ref(p);
            check_ctrl(ssa_ctrl_o[p], want, p);
            check_flit_wr(ssa_ctrl_o[p].ssa_flit_wr, want.ssa_flit_wr, p);
            wr_next[p] = rst_n_i & feed_sw_grant(p);
        end
        exp_wr_q = wr_next;
    end

    task automatic clear_inputs();
        flit_in_wr_i       = '0;
        any_ovc_granted_i  = '0;
        any_ivc_sw_grant_i = '0;
        for (int p = 0; p < `SSA_P; p++) begin
            flit_in_i[p]   = '0;
            ovc_avail_i[p] = '1;    // all output vcs free
            ovc_full_i[p]  = '0;
            for (int v = 0; v < `SSA_V; v++) begin
                ivc_info_i[p][v] = '0;
            end
        end
    endtask

    task automatic clear_expect();
        for (int p = 0; p < `SSA_P; p++) begin
            exp_c[p] = '0;
        end
    endtask

    task automatic check_all();
        for (int p = 0; p < `SSA_P; p++) begin
            check_ctrl(ssa_ctrl_o[p], exp_c[p], p);
            check_flit_wr(ssa_ctrl_o[p].ssa_flit_wr, exp_c[p].ssa_flit_wr, p);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic to_sample();
        #(SAMPLE_DLY - DRIVE_DLY);
    endtask

    // quiet cycle, strobe only on wr_port (or none for -1)
    task automatic idle_check(input int wr_port);
        next_cycle();
        clear_inputs();
        to_sample();
        clear_expect();
        if (wr_port >= 0) begin
            exp_c[wr_port].ssa_flit_wr = 1'b1;
        end
        check_all();
    endtask

    task automatic assign_ovc(input int p, input int v);
        ivc_info_i[p][v].ovc_is_assigned = 1'b1;
        ivc_info_i[p][v].assigned_ovc    = '0;
        ivc_info_i[p][v].assigned_ovc[v] = 1'b1;
        ivc_info_i[p][v].dest_port       = port_num_t'(partner_of(p));
    endtask

    task automatic wait_reset_release(output logic released);
        int n;
        n = 0;
        while (rst_n_i !== 1'b1 && n < RST_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        released = (rst_n_i === 1'b1);
    endtask

    task automatic random_inputs();
        logic [15:0] r;
        int          s;
        for (int p = 0; p < `SSA_P; p++) begin
            s = partner_of(p);
            r = rand16();
            flit_in_wr_i[p] = r[0];
            flit_in_i[p]    = make_flit(r[1], r[2], int'(r[3]), r[4] ? s : int'(r[7:5]));
            flit_in_i[p][27:12]   = rand16();   // payload
            any_ovc_granted_i[p]  = (r[9:8] == 2'b00);
            any_ivc_sw_grant_i[p] = (r[11:10] == 2'b00);
            ovc_avail_i[p]        = r[13:12];
            ovc_full_i[p]         = r[15:14];
            for (int v = 0; v < `SSA_V; v++) begin
                r = rand16();
                ivc_info_i[p][v].ivc_req         = (r[1:0] == 2'b00);
                ivc_info_i[p][v].ovc_is_assigned = r[2];
                ivc_info_i[p][v].assigned_ovc    = r[4:3];
                ivc_info_i[p][v].dest_port       = r[5] ? port_num_t'(s) : r[8:6];
            end
        end
    endtask

    task automatic directed_tests();
        idle_check(-1);

        // west header bound east
        next_cycle();
        clear_inputs();
        flit_in_wr_i[WEST] = 1'b1;
        flit_in_i[WEST]    = make_flit(1'b1, 1'b0, 0, EAST);
        to_sample();
        clear_expect();
        exp_c[WEST].ivc_num_getting_sw_grant[0]  = 1'b1;
        exp_c[WEST].ivc_num_getting_ovc_grant[0] = 1'b1;
        exp_c[WEST].ivc_granted_ovc_num[0][0]    = 1'b1;
        exp_c[EAST].ovc_is_allocated[0]          = 1'b1;
        exp_c[EAST].buff_space_decreased[0]      = 1'b1;
        check_all();
        idle_check(EAST);

        // one blocking condition at a time
        for (int blk = 0; blk < 5; blk++) begin
            next_cycle();
            clear_inputs();
            flit_in_wr_i[WEST] = 1'b1;
            flit_in_i[WEST]    = make_flit(1'b1, 1'b0, 0, EAST);
            case (blk)
                0:       ivc_info_i[WEST][0].ivc_req = 1'b1;
                1:       any_ivc_sw_grant_i[WEST] = 1'b1;
                2:       any_ovc_granted_i[EAST] = 1'b1;
                3:       ovc_avail_i[EAST] = '0;
                default: flit_in_i[WEST] = make_flit(1'b1, 1'b0, 0, NORTH);
            endcase
            to_sample();
            clear_expect();
            check_all();
            idle_check(-1);
        end

        // body then tail on an assigned ovc
        for (int tl = 0; tl < 2; tl++) begin
            next_cycle();
            clear_inputs();
            assign_ovc(WEST, 1);
            flit_in_wr_i[WEST] = 1'b1;
            flit_in_i[WEST]    = make_flit(1'b0, tl[0], 1, 0);
            to_sample();
            clear_expect();
            exp_c[WEST].ivc_num_getting_sw_grant[1] = 1'b1;
            exp_c[EAST].buff_space_decreased[1]     = 1'b1;
            exp_c[WEST].ivc_reset[1]                = tl[0];
            exp_c[EAST].ovc_is_released[1]          = tl[0];
            check_all();
            idle_check(EAST);
        end

        // single-flit packet
        next_cycle();
        clear_inputs();
        flit_in_wr_i[WEST] = 1'b1;
        flit_in_i[WEST]    = make_flit(1'b1, 1'b1, 0, EAST);
        to_sample();
        clear_expect();
        exp_c[WEST].ivc_num_getting_sw_grant[0]  = 1'b1;
        exp_c[WEST].ivc_num_getting_ovc_grant[0] = 1'b1;
        exp_c[WEST].ivc_granted_ovc_num[0][0]    = 1'b1;
        exp_c[WEST].ivc_reset[0]                 = 1'b1;
        exp_c[WEST].ivc_single_flit_pck[0]       = 1'b1;
        exp_c[EAST].buff_space_decreased[0]      = 1'b1;
        exp_c[EAST].ovc_single_flit_pck[0]       = 1'b1;
        check_all();
        idle_check(EAST);

        // local port has no straight path
        next_cycle();
        clear_inputs();
        flit_in_wr_i[LOCAL] = 1'b1;
        flit_in_i[LOCAL]    = make_flit(1'b1, 1'b1, 1, EAST);
        to_sample();
        clear_expect();
        check_all();
        idle_check(-1);
    endtask

    task automatic random_traffic();
        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            next_cycle();
            random_inputs();
        end
        next_cycle();
        clear_inputs();
        repeat (2) @(posedge clk);
    endtask

    initial begin
        for (int n = 0; n < MAX_CYCLES && !sim_done; n++) begin
            @(posedge clk);
        end
        if (!sim_done) begin
            $display("run did not complete within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic rst_ok;
        clk = 1'b0;
        clear_inputs();
        wait_reset_release(rst_ok);
        if (!rst_ok) begin
            $display("reset was not released within %0d cycles", RST_TIMEOUT);
            $display("TESTS FAILED");
        end else begin
            directed_tests();
            random_traffic();

            sim_done = 1'b1;
            $display("errors: %0d control mismatches, %0d write strobe mismatches",
                     ctrl_errs, wr_errs);
            if (ctrl_errs == 0 && wr_errs == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/ssa_pkg.sv
src/ssa_flit_decode.sv
src/ssa_vc_decide.sv
src/ssa_port_ctrl.sv
src/ss_allocator.sv
testbench/tb_ss_allocator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the straight allocator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_ss_allocator

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
